//--- logic/rs_cfg.svh
//////////////////////////////////////////////////
// Sizes and latencies for the issue stage
// Physical register, ROB and station sizes
// Data width and multiplier latency
//////////////////////////////////////////////////
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

`define PRN_SIZE     32                   // Physical registers
`define ROB_SIZE     16                   // ROB entries
`define RS_SIZE      4                    // Reservation station entries
`define XLEN         64                   // Data width
`define MULT_CYCLES  4                    // Issue cycle to CDB2 cycle, at least 2

`define TAG_W        $clog2(`PRN_SIZE)    // Physical tag width
`define ROB_W        $clog2(`ROB_SIZE)    // ROB index width

`endif

//--- logic/rs_pkg.sv
//////////////////////////////////////////////////
// Shared types for the issue stage
// Opcodes, unit classes, multiplier states
// Opcode to unit class decode
//////////////////////////////////////////////////
package rs_pkg;

	typedef enum logic [5:0] {
		OP_ADD   = 6'h00,                   // Zero so idle entry outputs merge cleanly
		OP_SUB   = 6'h01,
		OP_AND   = 6'h02,
		OP_OR    = 6'h03,
		OP_XOR   = 6'h04,
		OP_MUL   = 6'h05,
		OP_STORE = 6'h06
	} op_e;

	typedef enum logic [1:0] {
		USE_ADDER      = 2'd0,
		USE_MULTIPLIER = 2'd1,
		USE_MEMORY     = 2'd2
	} fu_e;

	typedef enum logic {
		MULT_IDLE,                           // Free for a new multiply
		MULT_BUSY                            // Counting down or broadcasting
	} mult_state_e;

	// Unit class of an opcode, used by entries and the issue selector
	function automatic fu_e fu_of_op(input op_e op);
		case (op)
		OP_MUL:   return USE_MULTIPLIER;
		OP_STORE: return USE_MEMORY;
		default:  return USE_ADDER;       // Every logic op runs on the ALU
		endcase
	endfunction

endpackage

//--- logic/rs_one_entry.sv
//////////////////////////////////////////////////
// Single reservation station entry
// Holds one instruction, snoops CDB1 and CDB2
// Reports ready once operands and unit allow
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_one_entry import rs_pkg::*;
(
	input  logic               clock,
	input  logic               reset,
	input  logic               load,              // Take the dispatched instruction
	input  op_e                op,
	input  logic [`XLEN-1:0]   opa,               // Value, or tag in the low bits
	input  logic [`XLEN-1:0]   opb,
	input  logic               opa_valid,         // 1 means opa holds data
	input  logic               opb_valid,
	input  logic [`TAG_W-1:0]  dest_tag,
	input  logic [`ROB_W-1:0]  rob_idx,
	input  logic               cdb1_valid,
	input  logic [`TAG_W-1:0]  cdb1_tag,
	input  logic [`XLEN-1:0]   cdb1_data,
	input  logic               cdb2_valid,
	input  logic [`TAG_W-1:0]  cdb2_tag,
	input  logic [`XLEN-1:0]   cdb2_data,
	input  logic               adder_available,
	input  logic               mult_available,
	input  logic               memory_available,
	input  logic               use_enable,        // Selected for issue this cycle
	output logic               ready,
	output logic               available,         // Entry is free
	output logic [`XLEN-1:0]   opa_out,
	output logic [`XLEN-1:0]   opb_out,
	output logic [`TAG_W-1:0]  dest_tag_out,
	output logic [`ROB_W-1:0]  rob_idx_out,
	output op_e                op_out
);

	logic               in_use;
	logic               opa_valid_reg;
	logic               opb_valid_reg;
	logic [`XLEN-1:0]   opa_reg;
	logic [`XLEN-1:0]   opb_reg;
	logic [`TAG_W-1:0]  dest_tag_reg;
	logic [`ROB_W-1:0]  rob_idx_reg;
	op_e                op_reg;
	fu_e                fu_class;
	logic               fu_ready;
	logic               a_cdb1, b_cdb1;           // Tag hits on CDB1
	logic               a_cdb2, b_cdb2;           // Tag hits on CDB2

	//////////////////////////////////////////////////
	// Wakeup and readiness
	//////////////////////////////////////////////////
	assign a_cdb1 = in_use && !opa_valid_reg && cdb1_valid && (opa_reg[`TAG_W-1:0] == cdb1_tag);
	assign b_cdb1 = in_use && !opb_valid_reg && cdb1_valid && (opb_reg[`TAG_W-1:0] == cdb1_tag);
	assign a_cdb2 = in_use && !opa_valid_reg && cdb2_valid && (opa_reg[`TAG_W-1:0] == cdb2_tag);
	assign b_cdb2 = in_use && !opb_valid_reg && cdb2_valid && (opb_reg[`TAG_W-1:0] == cdb2_tag);

	assign fu_class = fu_of_op(op_reg);

	always_comb
	begin
		case (fu_class)
		USE_ADDER:      fu_ready = adder_available;
		USE_MULTIPLIER: fu_ready = mult_available;
		USE_MEMORY:     fu_ready = memory_available;
		default:        fu_ready = 1'b0;
		endcase
	end

	assign available = ~in_use;
	assign ready     = in_use & opa_valid_reg & opb_valid_reg & fu_ready;

	// Outputs are zero unless selected, so the selector can OR them
	assign opa_out      = use_enable ? opa_reg : '0;
	assign opb_out      = use_enable ? opb_reg : '0;
	assign dest_tag_out = use_enable ? dest_tag_reg : '0;
	assign rob_idx_out  = use_enable ? rob_idx_reg : '0;
	assign op_out       = use_enable ? op_reg : op_e'('0);

	//////////////////////////////////////////////////
	// State
	//////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			in_use        <= 1'b0;
			opa_valid_reg <= 1'b0;
			opb_valid_reg <= 1'b0;
		end
		else if (load)                        // Load beats wakeup and release
		begin
			in_use        <= 1'b1;
			opa_valid_reg <= opa_valid;
			opb_valid_reg <= opb_valid;
		end
		else
		begin
			if (a_cdb1 || a_cdb2)
				opa_valid_reg <= 1'b1;
			if (b_cdb1 || b_cdb2)
				opb_valid_reg <= 1'b1;
			if (use_enable)
				in_use <= 1'b0;               // Sent to its unit
		end
	end

	always_ff @(posedge clock)
	begin
		if (load)
		begin
			opa_reg      <= opa;
			opb_reg      <= opb;
			op_reg       <= op;
			dest_tag_reg <= dest_tag;
			rob_idx_reg  <= rob_idx;
		end
		else
		begin
			if (a_cdb1)
				opa_reg <= cdb1_data;
			if (a_cdb2)
				opa_reg <= cdb2_data;          // CDB2 wins on a double hit
			if (b_cdb1)
				opb_reg <= cdb1_data;
			if (b_cdb2)
				opb_reg <= cdb2_data;
		end
	end

endmodule

//--- logic/rs_alloc.sv
//////////////////////////////////////////////////
// Dispatch allocator
// Steers a dispatch to the lowest free entry
// Flags a full station
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_alloc import rs_pkg::*;
(
	input  logic                 dispatch_valid,    // Rename has an instruction
	input  logic [`RS_SIZE-1:0]  entry_available,   // One bit per free entry
	output logic [`RS_SIZE-1:0]  load,              // One-hot load strobe
	output logic                 rs_full
);

	logic [`RS_SIZE-1:0]  lowest_free;             // One-hot lowest free entry
	logic                 found;

	// Priority encoder, entry 0 first
	always_comb
	begin
		lowest_free = '0;
		found       = 1'b0;
		for (int i = 0; i < `RS_SIZE; i++)
		begin
			if (entry_available[i] && !found)
			begin
				lowest_free[i] = 1'b1;
				found          = 1'b1;
			end
		end
	end

	assign rs_full = ~found;                     // No free entry left

	// Dispatch while full has no free bit to land on
	assign load = dispatch_valid ? lowest_free : '0;

endmodule

//--- logic/rs_issue_select.sv
//////////////////////////////////////////////////
// Issue selector
// Picks the lowest ready entry
// OR-merges entry outputs, decodes issue strobes
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_issue_select import rs_pkg::*;
(
	input  logic [`RS_SIZE-1:0]              entry_ready,
	input  logic [`RS_SIZE-1:0][`XLEN-1:0]   entry_opa,       // Zero unless enabled
	input  logic [`RS_SIZE-1:0][`XLEN-1:0]   entry_opb,
	input  logic [`RS_SIZE-1:0][`TAG_W-1:0]  entry_dest_tag,
	input  logic [`RS_SIZE-1:0][`ROB_W-1:0]  entry_rob_idx,
	input  op_e  [`RS_SIZE-1:0]              entry_op,
	output logic [`RS_SIZE-1:0]              use_enable,      // One-hot grant
	output logic                             alu_issue,
	output logic                             mult_issue,
	output logic                             store_valid,
	output op_e                              issue_op,
	output logic [`XLEN-1:0]                 issue_opa,
	output logic [`XLEN-1:0]                 issue_opb,
	output logic [`TAG_W-1:0]                issue_dest_tag,
	output logic [`ROB_W-1:0]                issue_rob_idx
);

	logic        any_ready;
	logic [5:0]  op_bits;                          // Merged opcode before cast
	fu_e         issue_fu;

	//////////////////////////////////////////////////
	// Grant
	//////////////////////////////////////////////////
	always_comb
	begin
		use_enable = '0;
		any_ready  = 1'b0;
		for (int i = 0; i < `RS_SIZE; i++)
		begin
			if (entry_ready[i] && !any_ready)   // Lowest index wins
			begin
				use_enable[i] = 1'b1;
				any_ready     = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Merge
	//////////////////////////////////////////////////
	always_comb
	begin
		issue_opa      = '0;
		issue_opb      = '0;
		issue_dest_tag = '0;
		issue_rob_idx  = '0;
		op_bits        = '0;
		for (int i = 0; i < `RS_SIZE; i++)
		begin
			issue_opa      = issue_opa | entry_opa[i];
			issue_opb      = issue_opb | entry_opb[i];
			issue_dest_tag = issue_dest_tag | entry_dest_tag[i];
			issue_rob_idx  = issue_rob_idx | entry_rob_idx[i];
			op_bits        = op_bits | entry_op[i];
		end
	end

	assign issue_op = op_e'(op_bits);
	assign issue_fu = fu_of_op(issue_op);

	// Exactly one strobe when something issues
	assign alu_issue   = any_ready && (issue_fu == USE_ADDER);
	assign mult_issue  = any_ready && (issue_fu == USE_MULTIPLIER);
	assign store_valid = any_ready && (issue_fu == USE_MEMORY);

endmodule

//--- logic/alu_unit.sv
//////////////////////////////////////////////////
// Single-cycle integer unit
// Add, sub, and, or, xor, result onto CDB1
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rs_cfg.svh"

module alu_unit import rs_pkg::*;
(
	input  logic               clock,
	input  logic               reset,
	input  logic               issue,              // Operands valid this cycle
	input  op_e                op,
	input  logic [`XLEN-1:0]   opa,
	input  logic [`XLEN-1:0]   opb,
	input  logic [`TAG_W-1:0]  dest_tag,
	input  logic [`ROB_W-1:0]  rob_idx,
	output logic               cdb_valid,
	output logic [`TAG_W-1:0]  cdb_tag,
	output logic [`XLEN-1:0]   cdb_data,
	output logic [`ROB_W-1:0]  cdb_rob_idx
);

	logic [`XLEN-1:0]  result;

	always_comb
	begin
		case (op)
		OP_ADD:  result = opa + opb;
		OP_SUB:  result = opa - opb;
		OP_AND:  result = opa & opb;
		OP_OR:   result = opa | opb;
		OP_XOR:  result = opa ^ opb;
		default: result = '0;                  // Not an ALU op
		endcase
	end

	// Broadcast in the cycle after issue
	always_ff @(posedge clock)
	begin
		if (reset)
			cdb_valid <= 1'b0;
		else
			cdb_valid <= issue;
	end

	always_ff @(posedge clock)
	begin
		if (issue)
		begin
			cdb_data    <= result;
			cdb_tag     <= dest_tag;
			cdb_rob_idx <= rob_idx;
		end
	end

endmodule

//--- logic/mult_unit.sv
//////////////////////////////////////////////////
// Unpipelined multiplier
// Busy for MULT_CYCLES, low half onto CDB2
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rs_cfg.svh"

module mult_unit import rs_pkg::*;
(
	input  logic               clock,
	input  logic               reset,
	input  logic               issue,              // Only while available
	input  logic [`XLEN-1:0]   opa,
	input  logic [`XLEN-1:0]   opb,
	input  logic [`TAG_W-1:0]  dest_tag,
	input  logic [`ROB_W-1:0]  rob_idx,
	output logic               available,
	output logic               cdb_valid,
	output logic [`TAG_W-1:0]  cdb_tag,
	output logic [`XLEN-1:0]   cdb_data,
	output logic [`ROB_W-1:0]  cdb_rob_idx
);

	localparam int CNT_W = $clog2(`MULT_CYCLES);

	mult_state_e          state;
	logic [CNT_W-1:0]     count;                   // Cycles left before broadcast
	logic [`XLEN-1:0]     opa_reg;
	logic [`XLEN-1:0]     opb_reg;
	logic [2*`XLEN-1:0]   product;
	logic                 finish;                  // Last edge before broadcast

	assign product   = opa_reg * opb_reg;
	assign finish    = (state == MULT_BUSY) && !cdb_valid && (count == '0);
	assign available = (state == MULT_IDLE);     // Low through the broadcast cycle

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state     <= MULT_IDLE;
			count     <= '0;
			cdb_valid <= 1'b0;
		end
		else
		begin
			case (state)
			MULT_IDLE:
				if (issue)
				begin
					state <= MULT_BUSY;
					count <= CNT_W'(`MULT_CYCLES - 2); // Issue cycle plus broadcast cycle
				end
			MULT_BUSY:
				if (cdb_valid)
				begin
					cdb_valid <= 1'b0;         // One broadcast cycle only
					state     <= MULT_IDLE;
				end
				else if (finish)
					cdb_valid <= 1'b1;
				else
					count <= count - 1'b1;
			default:
				state <= MULT_IDLE;
			endcase
		end
	end

	// Operands held for the whole multiply
	always_ff @(posedge clock)
	begin
		if (issue && available)
		begin
			opa_reg     <= opa;
			opb_reg     <= opb;
			cdb_tag     <= dest_tag;
			cdb_rob_idx <= rob_idx;
		end
		if (finish)
			cdb_data <= product[`XLEN-1:0];   // Low half only
	end

endmodule

//--- logic/rs_top.sv
//////////////////////////////////////////////////
// Issue stage top level
// Entries, allocator, selector, ALU, multiplier
// Store port and CDB outputs
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_top import rs_pkg::*;
(
	input  logic               clock,
	input  logic               reset,
	input  logic               dispatch_valid,
	input  op_e                dispatch_op,
	input  logic [`XLEN-1:0]   dispatch_opa,
	input  logic               dispatch_opa_valid,
	input  logic [`XLEN-1:0]   dispatch_opb,
	input  logic               dispatch_opb_valid,
	input  logic [`TAG_W-1:0]  dispatch_dest_tag,
	input  logic [`ROB_W-1:0]  dispatch_rob_idx,
	input  logic               memory_available,   // Level from the memory side
	output logic               rs_full,
	output logic               cdb1_valid,
	output logic [`TAG_W-1:0]  cdb1_tag,
	output logic [`XLEN-1:0]   cdb1_data,
	output logic [`ROB_W-1:0]  cdb1_rob_idx,
	output logic               cdb2_valid,
	output logic [`TAG_W-1:0]  cdb2_tag,
	output logic [`XLEN-1:0]   cdb2_data,
	output logic [`ROB_W-1:0]  cdb2_rob_idx,
	output logic               store_valid,
	output logic [`XLEN-1:0]   store_addr,
	output logic [`XLEN-1:0]   store_data,
	output logic [`ROB_W-1:0]  store_rob_idx
);

	logic [`RS_SIZE-1:0]              entry_load;
	logic [`RS_SIZE-1:0]              entry_available;
	logic [`RS_SIZE-1:0]              entry_ready;
	logic [`RS_SIZE-1:0]              use_enable;
	logic [`RS_SIZE-1:0][`XLEN-1:0]   entry_opa;
	logic [`RS_SIZE-1:0][`XLEN-1:0]   entry_opb;
	logic [`RS_SIZE-1:0][`TAG_W-1:0]  entry_dest_tag;
	logic [`RS_SIZE-1:0][`ROB_W-1:0]  entry_rob_idx;
	op_e  [`RS_SIZE-1:0]              entry_op;
	op_e                              issue_op;
	logic [`XLEN-1:0]                 issue_opa, issue_opb;
	logic [`TAG_W-1:0]                issue_dest_tag;
	logic [`ROB_W-1:0]                issue_rob_idx;
	logic                             alu_issue, mult_issue;
	logic                             mult_available;

	//////////////////////////////////////////////////
	// Station
	//////////////////////////////////////////////////
	rs_alloc alloc (.dispatch_valid, .entry_available, .load(entry_load), .rs_full);

	for (genvar i = 0; i < `RS_SIZE; i++)
	begin : g_entry
		rs_one_entry entry (
			.clock, .reset, .load(entry_load[i]), .op(dispatch_op),
			.opa(dispatch_opa), .opb(dispatch_opb),
			.opa_valid(dispatch_opa_valid), .opb_valid(dispatch_opb_valid),
			.dest_tag(dispatch_dest_tag), .rob_idx(dispatch_rob_idx),
			.cdb1_valid, .cdb1_tag, .cdb1_data, .cdb2_valid, .cdb2_tag, .cdb2_data,
			.adder_available(1'b1), .mult_available, .memory_available, // ALU never stalls
			.use_enable(use_enable[i]), .ready(entry_ready[i]),
			.available(entry_available[i]), .opa_out(entry_opa[i]), .opb_out(entry_opb[i]),
			.dest_tag_out(entry_dest_tag[i]), .rob_idx_out(entry_rob_idx[i]),
			.op_out(entry_op[i]));
	end

	rs_issue_select select (
		.entry_ready, .entry_opa, .entry_opb, .entry_dest_tag, .entry_rob_idx, .entry_op,
		.use_enable, .alu_issue, .mult_issue, .store_valid, .issue_op,
		.issue_opa, .issue_opb, .issue_dest_tag, .issue_rob_idx);

	//////////////////////////////////////////////////
	// Units and store port
	//////////////////////////////////////////////////
	alu_unit alu (
		.clock, .reset, .issue(alu_issue), .op(issue_op), .opa(issue_opa), .opb(issue_opb),
		.dest_tag(issue_dest_tag), .rob_idx(issue_rob_idx), .cdb_valid(cdb1_valid),
		.cdb_tag(cdb1_tag), .cdb_data(cdb1_data), .cdb_rob_idx(cdb1_rob_idx));

	mult_unit mult (
		.clock, .reset, .issue(mult_issue), .opa(issue_opa), .opb(issue_opb),
		.dest_tag(issue_dest_tag), .rob_idx(issue_rob_idx), .available(mult_available),
		.cdb_valid(cdb2_valid), .cdb_tag(cdb2_tag), .cdb_data(cdb2_data),
		.cdb_rob_idx(cdb2_rob_idx));

	assign store_addr    = issue_opa;              // Meaningful only with store_valid
	assign store_data    = issue_opb;
	assign store_rob_idx = issue_rob_idx;

endmodule

//--- dv/clock_gen.sv
//////////////////////////////////////////////////
// Testbench clock and reset source
// 20 ns clock, reset high for 3 cycles
//////////////////////////////////////////////////
`timescale 1ns/1ps

module clock_gen
(
	output logic  clock,
	output logic  reset
);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;          // 20 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clock);         // Three reset edges
		#2 reset = 1'b0;                     // Released with the other inputs
	end

endmodule

//--- dv/rs_tb.sv
//////////////////////////////////////////////////
// Testbench for the issue stage
// Directed tests for ALU, multiplier, chains,
// stores and a full station
// CDB and store monitor, checks, cycle limit
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_tb import rs_pkg::*;
();

	localparam int CYCLE_LIMIT  = 2000;      // Whole run, all tests
	localparam int EVENT_WINDOW = 40;        // Cycles to wait for one result

	typedef struct packed {
		logic [`TAG_W-1:0]  tag;
		logic [`XLEN-1:0]   data;
		logic [`ROB_W-1:0]  rob;
		logic [31:0]        cyc;             // Cycle it was seen
	} cdb_event_t;

	typedef struct packed {
		logic [`XLEN-1:0]   addr;
		logic [`XLEN-1:0]   data;
		logic [`ROB_W-1:0]  rob;
		logic [31:0]        cyc;
	} store_event_t;

	logic               clock, reset;
	logic               dispatch_valid;
	op_e                dispatch_op;
	logic [`XLEN-1:0]   dispatch_opa, dispatch_opb;
	logic               dispatch_opa_valid, dispatch_opb_valid;
	logic [`TAG_W-1:0]  dispatch_dest_tag;
	logic [`ROB_W-1:0]  dispatch_rob_idx;
	logic               memory_available;
	logic               rs_full;
	logic               cdb1_valid, cdb2_valid, store_valid;
	logic [`TAG_W-1:0]  cdb1_tag, cdb2_tag;
	logic [`XLEN-1:0]   cdb1_data, cdb2_data, store_addr, store_data;
	logic [`ROB_W-1:0]  cdb1_rob_idx, cdb2_rob_idx, store_rob_idx;

	int                 cycle = 0;
	int                 value_errors = 0;
	int                 event_errors = 0;
	integer             seed;
	cdb_event_t         cdb1_q[$];
	cdb_event_t         cdb2_q[$];
	store_event_t       store_q[$];

	clock_gen clocks (.clock, .reset);

	rs_top UUT (
		.clock, .reset, .dispatch_valid, .dispatch_op, .dispatch_opa, .dispatch_opa_valid,
		.dispatch_opb, .dispatch_opb_valid, .dispatch_dest_tag, .dispatch_rob_idx,
		.memory_available, .rs_full,
		.cdb1_valid, .cdb1_tag, .cdb1_data, .cdb1_rob_idx,
		.cdb2_valid, .cdb2_tag, .cdb2_data, .cdb2_rob_idx,
		.store_valid, .store_addr, .store_data, .store_rob_idx);

	//////////////////////////////////////////////////
	// Cycle limit and result monitor
	//////////////////////////////////////////////////
	always @(posedge clock)
	begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT)
		begin
			$display("Run stopped at the limit of %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

	always @(negedge clock)                 // Outputs settled mid-cycle
	begin
		if (!reset && cdb1_valid)
			cdb1_q.push_back({cdb1_tag, cdb1_data, cdb1_rob_idx, cycle});
		if (!reset && cdb2_valid)
			cdb2_q.push_back({cdb2_tag, cdb2_data, cdb2_rob_idx, cycle});
		if (!reset && store_valid)
			store_q.push_back({store_addr, store_data, store_rob_idx, cycle});
	end

	//////////////////////////////////////////////////
	// Model and checks
	//////////////////////////////////////////////////
	function automatic logic [`XLEN-1:0] model_result(input op_e op,
		input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		case (op)
		OP_ADD:  return a + b;
		OP_SUB:  return a - b;
		OP_AND:  return a & b;
		OP_OR:   return a | b;
		OP_XOR:  return a ^ b;
		OP_MUL:  return a * b;               // Low half of the product
		default: return '0;
		endcase
	endfunction

	function automatic op_e alu_op(input int k);
		case (k % 5)
		0:       return OP_ADD;
		1:       return OP_SUB;
		2:       return OP_AND;
		3:       return OP_OR;
		default: return OP_XOR;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] random_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic int pending(input int kind);
		case (kind)
		1:       return cdb1_q.size();
		2:       return cdb2_q.size();
		default: return store_q.size();
		endcase
	endfunction

	task automatic compare_cdb(input string what,
		input logic [`TAG_W-1:0] tag, input logic [`TAG_W-1:0] exp_tag,
		input logic [`XLEN-1:0] data, input logic [`XLEN-1:0] exp_data,
		input logic [`ROB_W-1:0] rob, input logic [`ROB_W-1:0] exp_rob);
		if (tag !== exp_tag || data !== exp_data || rob !== exp_rob)
		begin
			value_errors++;
			$display("ERR %0t: %s got tag %0d data %h rob %0d", $time, what, tag, data, rob);
			$display("ERR %0t: %s expected tag %0d data %h rob %0d", $time, what,
				exp_tag, exp_data, exp_rob);
		end
	endtask

	task automatic compare_store(input string what,
		input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] exp_addr,
		input logic [`XLEN-1:0] data, input logic [`XLEN-1:0] exp_data,
		input logic [`ROB_W-1:0] rob, input logic [`ROB_W-1:0] exp_rob);
		if (addr !== exp_addr || data !== exp_data || rob !== exp_rob)
		begin
			value_errors++;
			$display("ERR %0t: %s got addr %h data %h rob %0d, expected %h %h %0d", $time,
				what, addr, data, rob, exp_addr, exp_data, exp_rob);
		end
	endtask

	task automatic compare_flag(input string what, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			value_errors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic check_latency(input string what, input int seen_cyc, input int start_cyc,
		input int latency);
		if (latency >= 0 && seen_cyc - start_cyc != latency)
		begin
			value_errors++;
			$display("ERR %0t: %s came after %0d cycles, expected %0d", $time, what,
				seen_cyc - start_cyc, latency);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////
	task automatic next_drive_slot();
		@(posedge clock);
		#2;                                  // Inputs change 2 ns after the edge
	endtask

	task automatic send_instr(input op_e op, input logic [`XLEN-1:0] a, input logic a_valid,
		input logic [`XLEN-1:0] b, input logic b_valid, input logic [`TAG_W-1:0] tag,
		input logic [`ROB_W-1:0] rob, output int sent_cyc);
		dispatch_valid     = 1'b1;
		dispatch_op        = op;
		dispatch_opa       = a;
		dispatch_opa_valid = a_valid;
		dispatch_opb       = b;
		dispatch_opb_valid = b_valid;
		dispatch_dest_tag  = tag;
		dispatch_rob_idx   = rob;
		next_drive_slot();                   // Taken at this edge
		dispatch_valid     = 1'b0;
		sent_cyc           = cycle;
	endtask

	task automatic wait_event(input int kind, output bit found);
		int waited;
		waited = 0;
		while (pending(kind) == 0 && waited < EVENT_WINDOW)
		begin
			@(negedge clock);
			#1;                              // Let the monitor push first
			waited++;
		end
		found = (pending(kind) != 0);
	endtask

	task automatic expect_cdb(input int bus, input string what, input logic [`TAG_W-1:0] tag,
		input logic [`XLEN-1:0] data, input logic [`ROB_W-1:0] rob, input int start_cyc,
		input int latency, output int seen_cyc);
		cdb_event_t ev;
		bit         found;
		seen_cyc = -1;
		wait_event(bus, found);
		if (!found)
		begin
			event_errors++;
			$display("%s never appeared on CDB%0d within %0d cycles", what, bus, EVENT_WINDOW);
		end
		else
		begin
			if (bus == 1)
				ev = cdb1_q.pop_front();
			else
				ev = cdb2_q.pop_front();
			seen_cyc = int'(ev.cyc);
			compare_cdb(what, ev.tag, tag, ev.data, data, ev.rob, rob);
			check_latency(what, seen_cyc, start_cyc, latency);
		end
	endtask

	task automatic expect_store(input string what, input logic [`XLEN-1:0] addr,
		input logic [`XLEN-1:0] data, input logic [`ROB_W-1:0] rob, input int start_cyc);
		store_event_t ev;
		bit           found;
		wait_event(3, found);
		if (!found)
		begin
			event_errors++;
			$display("%s never appeared on the store port within %0d cycles", what,
				EVENT_WINDOW);
		end
		else
		begin
			ev = store_q.pop_front();
			compare_store(what, ev.addr, addr, ev.data, data, ev.rob, rob);
			check_latency(what, int'(ev.cyc), start_cyc, 0);   // Same cycle as issue
		end
	endtask

	task automatic expect_quiet(input string what);
		repeat (4) next_drive_slot();
		if (pending(1) != 0 || pending(2) != 0 || pending(3) != 0)
		begin
			event_errors++;
			$display("Unexpected extra results appeared during %s", what);
		end
		cdb1_q.delete();
		cdb2_q.delete();
		store_q.delete();
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic check_alu_ops();
		logic [`XLEN-1:0]   a, b;
		logic [`TAG_W-1:0]  tag;
		logic [`ROB_W-1:0]  rob;
		int                 sent, seen;
		for (int k = 0; k < 5; k++)
		begin
			a   = random_word();
			b   = random_word();
			tag = `TAG_W'(k + 1);
			rob = `ROB_W'(k);
			send_instr(alu_op(k), a, 1'b1, b, 1'b1, tag, rob, sent);
			expect_cdb(1, "ALU result", tag, model_result(alu_op(k), a, b), rob, sent, 1, seen);
			next_drive_slot();
		end
		expect_quiet("ALU ops");
	endtask

	task automatic multiply_pair();
		logic [`XLEN-1:0]  a1, b1, a2, b2;
		int                sent1, sent2, seen;
		a1 = random_word();
		b1 = random_word();
		a2 = random_word();
		b2 = random_word();
		send_instr(OP_MUL, a1, 1'b1, b1, 1'b1, 5'd8, 4'd1, sent1);
		send_instr(OP_MUL, a2, 1'b1, b2, 1'b1, 5'd9, 4'd2, sent2);   // Waits for the unit
		expect_cdb(2, "First multiply", 5'd8, model_result(OP_MUL, a1, b1), 4'd1, sent1,
			`MULT_CYCLES, seen);
		expect_cdb(2, "Second multiply", 5'd9, model_result(OP_MUL, a2, b2), 4'd2, sent2,
			2 * `MULT_CYCLES, seen);
		expect_quiet("multiply pair");
	endtask

	task automatic dependency_chain();
		logic [`XLEN-1:0]  a, b, c, d, prod, sum;
		int                sent, seen_mul, seen_add, seen_dep;
		a    = random_word();
		b    = random_word();
		c    = random_word();
		d    = random_word();
		prod = model_result(OP_MUL, a, b);
		sum  = model_result(OP_ADD, c, d);
		send_instr(OP_MUL, a, 1'b1, b, 1'b1, 5'd10, 4'd3, sent);
		send_instr(OP_ADD, 64'd10, 1'b0, 64'd11, 1'b0, 5'd12, 4'd5, sent);  // Two tags
		send_instr(OP_ADD, c, 1'b1, d, 1'b1, 5'd11, 4'd4, sent);
		expect_cdb(2, "Chain multiply", 5'd10, prod, 4'd3, 0, -1, seen_mul);
		expect_cdb(1, "Chain producer add", 5'd11, sum, 4'd4, 0, -1, seen_add);
		expect_cdb(1, "Dependent add", 5'd12, model_result(OP_ADD, prod, sum), 4'd5, 0, -1,
			seen_dep);
		if (seen_dep >= 0 && (seen_dep <= seen_mul || seen_dep <= seen_add))
		begin
			value_errors++;
			$display("ERR %0t: dependent add finished before both producers", $time);
		end
		expect_quiet("dependency chain");
	endtask

	task automatic store_stall();
		logic [`XLEN-1:0]  addr, data, a, b;
		int                sent, seen, release_cyc;
		addr = random_word();
		data = random_word();
		a    = random_word();
		b    = random_word();
		memory_available = 1'b0;
		send_instr(OP_STORE, addr, 1'b1, data, 1'b1, 5'd0, 4'd6, sent);
		send_instr(OP_ADD, a, 1'b1, b, 1'b1, 5'd13, 4'd7, sent);     // Passes the store
		expect_cdb(1, "ALU op behind store", 5'd13, model_result(OP_ADD, a, b), 4'd7, sent, 1,
			seen);
		repeat (3) next_drive_slot();
		if (pending(3) != 0)
		begin
			value_errors++;
			$display("ERR %0t: store issued while memory was unavailable", $time);
			store_q.delete();
		end
		memory_available = 1'b1;
		release_cyc      = cycle;
		expect_store("Released store", addr, data, 4'd6, release_cyc);
		expect_quiet("store stall");
	endtask

	task automatic full_station();
		logic [`XLEN-1:0]  a1, b1, a2, b2, prod2;
		logic [`XLEN-1:0]  exp_data [`RS_SIZE];
		logic [`RS_SIZE-1:0] drained;
		cdb_event_t        ev;
		bit                found;
		int                sent, seen, waited, k;
		a1    = random_word();
		b1    = random_word();
		a2    = random_word();
		b2    = random_word();
		prod2 = model_result(OP_MUL, a2, b2);
		drained = '0;
		send_instr(OP_MUL, a1, 1'b1, b1, 1'b1, 5'd20, 4'd8, sent);
		send_instr(OP_MUL, a2, 1'b1, b2, 1'b1, 5'd21, 4'd9, sent);   // Its tag feeds the rest
		for (int i = 0; i < `RS_SIZE; i++)
		begin
			waited = 0;
			while (rs_full && waited < EVENT_WINDOW)   // Room frees when the mult issues
			begin
				next_drive_slot();
				waited++;
			end
			exp_data[i] = random_word();
			send_instr(alu_op(i), 64'd21, 1'b0, exp_data[i], 1'b1, `TAG_W'(22 + i),
				`ROB_W'(10 + i), sent);
			exp_data[i] = model_result(alu_op(i), prod2, exp_data[i]);
		end
		compare_flag("rs_full with all entries waiting", rs_full, 1'b1);
		send_instr(OP_ADD, 64'd1, 1'b1, 64'd2, 1'b1, 5'd31, 4'd15, sent);  // Must be dropped
		compare_flag("rs_full after dropped dispatch", rs_full, 1'b1);
		expect_cdb(2, "Full test first multiply", 5'd20, model_result(OP_MUL, a1, b1), 4'd8, 0,
			-1, seen);
		expect_cdb(2, "Full test second multiply", 5'd21, prod2, 4'd9, 0, -1, seen);
		for (int n = 0; n < `RS_SIZE; n++)
		begin
			wait_event(1, found);
			if (!found)
			begin
				event_errors++;
				$display("Only %0d of %0d waiting ops drained onto CDB1", n, `RS_SIZE);
				break;
			end
			ev = cdb1_q.pop_front();
			k  = int'(ev.rob) - 10;
			if (k < 0 || k >= `RS_SIZE)
			begin
				value_errors++;
				$display("ERR %0t: unexpected CDB1 result with rob %0d", $time, ev.rob);
			end
			else if (drained[k])
			begin
				value_errors++;
				$display("ERR %0t: rob %0d broadcast twice", $time, ev.rob);
			end
			else
			begin
				drained[k] = 1'b1;
				compare_cdb("Drained op", ev.tag, `TAG_W'(22 + k), ev.data, exp_data[k],
					ev.rob, `ROB_W'(10 + k));
			end
		end
		expect_quiet("full station");
		compare_flag("rs_full after drain", rs_full, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////
	initial
	begin
		seed               = 29;
		dispatch_valid     = 1'b0;
		dispatch_op        = OP_ADD;
		dispatch_opa       = '0;
		dispatch_opa_valid = 1'b0;
		dispatch_opb       = '0;
		dispatch_opb_valid = 1'b0;
		dispatch_dest_tag  = '0;
		dispatch_rob_idx   = '0;
		memory_available   = 1'b1;
		@(negedge reset);
		next_drive_slot();
		compare_flag("rs_full after reset", rs_full, 1'b0);
		compare_flag("cdb1_valid after reset", cdb1_valid, 1'b0);
		compare_flag("cdb2_valid after reset", cdb2_valid, 1'b0);
		compare_flag("store_valid after reset", store_valid, 1'b0);
		check_alu_ops();
		multiply_pair();
		dependency_chain();
		store_stall();
		full_station();
		$display("Errors: %0d wrong values, %0d missing or stray results", value_errors,
			event_errors);
		if (value_errors == 0 && event_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- files.f
+incdir+logic
logic/rs_pkg.sv
logic/rs_one_entry.sv
logic/rs_alloc.sv
logic/rs_issue_select.sv
logic/alu_unit.sv
logic/mult_unit.sv
logic/rs_top.sv
dv/clock_gen.sv
dv/rs_tb.sv
